// File: hw/ivc_assign_tracker.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module ivc_assign_tracker (
    input  logic                   clk,
    input  logic                   reset,
    vc_grant_if.tracker            grant,
    output noc_geom_pkg::pv_vec_t  ovc_is_assigned,
    output noc_geom_pkg::pvv_vec_t assigned_ovc_num,
    output noc_geom_pkg::pv_vec_t  credit_out
);

    localparam int V  = `NOC_VCS;
    localparam int PV = `NOC_PORTS * V;

    noc_geom_pkg::pv_vec_t  release_ivc;   // tail flit left through the switch
    noc_geom_pkg::pv_vec_t  assigned_next;
    noc_geom_pkg::pvv_vec_t ovc_num_next;

    assign release_ivc = grant.ivc_sw_grant & grant.flit_is_tail;

    // release has priority, the two never meet on one VC anyway
    always_comb begin
        assigned_next = ovc_is_assigned;
        ovc_num_next  = assigned_ovc_num;
        for (int k = 0; k < PV; k++) begin
            if (release_ivc[k]) begin
                assigned_next[k] = 1'b0;
            end else if (grant.ivc_ovc_grant[k]) begin
                assigned_next[k] = 1'b1;
            end
            if (grant.ivc_ovc_grant[k]) begin
                ovc_num_next[k*V +: V] = grant.granted_ovc_num[k*V +: V];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_is_assigned  <= '0;
            assigned_ovc_num <= '0;
            credit_out       <= '0;
        end else begin
            ovc_is_assigned  <= assigned_next;
            assigned_ovc_num <= ovc_num_next;
            // every flit that wins the switch frees one upstream slot
            credit_out       <= grant.ivc_sw_grant;
        end
    end

    // allocator must hand out a single output VC
    for (genvar g = 0; g < PV; g++) begin : g_chk
        a_grant_onehot: assert property (
            @(posedge clk) disable iff (reset)
            grant.ivc_ovc_grant[g] |-> $onehot(grant.granted_ovc_num[g*V +: V])
        ) else $error("ivc %0d granted a non one-hot ovc", g);
    end

    // a VC leaving and being re-granted in one cycle would lose the grant
    a_no_release_and_assign: assert property (
        @(posedge clk) disable iff (reset)
        (release_ivc & grant.ivc_ovc_grant) == '0
    ) else $error("ivc released and assigned in the same cycle");

endmodule

// File: hw/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// router geometry
`define NOC_PORTS     5 // P, local port included
`define NOC_VCS       4 // V per port

// flits per downstream input VC buffer
`define NOC_BUF_DEPTH 4

`endif

// File: hw/noc_geom_pkg.sv
`include "noc_cfg.svh"

package noc_geom_pkg;

    localparam int P = `NOC_PORTS;
    localparam int V = `NOC_VCS;

    // one bit per VC of a single port
    typedef logic [V-1:0] vc_vec_t;

    // one bit per VC over all ports
    typedef logic [P*V-1:0] pv_vec_t;

    // one-hot over the other P-1 ports, own port skipped
    typedef logic [P-2:0] dest_port_t;

    typedef logic [P*V*(P-1)-1:0] pv_dest_t; // dest_port_t per input VC

    // V-bit one-hot output VC per input VC
    typedef logic [P*V*V-1:0] pvv_vec_t;

endpackage

// File: hw/ovc_credit_tracker.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module ovc_credit_tracker (
    input  logic                  clk,
    input  logic                  reset,
    input  noc_geom_pkg::pv_vec_t ovc_wr,
    input  noc_geom_pkg::pv_vec_t credit_in,
    input  noc_geom_pkg::pv_vec_t ovc_allocated,
    input  noc_geom_pkg::pv_vec_t ovc_released,
    output noc_geom_pkg::pv_vec_t ovc_available,
    output noc_geom_pkg::pv_vec_t ovc_nearly_full,
    output noc_geom_pkg::pv_vec_t ovc_empty
);

    localparam int PV = `NOC_PORTS * `NOC_VCS;
    localparam int B  = `NOC_BUF_DEPTH;

    vc_state_pkg::depth_t  depth [PV]; // flits sent but not yet credited
    noc_geom_pkg::pv_vec_t owned;      // a packet holds this ovc

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owned <= '0;
            for (int k = 0; k < PV; k++) begin
                depth[k] <= '0;
            end
        end else begin
            // freed and re-taken in one cycle stays owned
            owned <= (owned & ~ovc_released) | ovc_allocated;
            for (int k = 0; k < PV; k++) begin
                if (ovc_wr[k] && !credit_in[k]) begin
                    depth[k] <= depth[k] + 1'b1;
                end else if (!ovc_wr[k] && credit_in[k]) begin
                    depth[k] <= depth[k] - 1'b1;
                end
            end
        end
    end

    assign ovc_available = ~owned;

    for (genvar k = 0; k < PV; k++) begin : g_ovc
        // one slot left counts as nearly full
        assign ovc_nearly_full[k] = (depth[k] >= vc_state_pkg::depth_t'(B - 1));
        assign ovc_empty[k]       = (depth[k] == '0);

        // credit for a flit that was never sent
        a_no_underflow: assert property (
            @(posedge clk) disable iff (reset)
            (credit_in[k] && !ovc_wr[k]) |-> (depth[k] != '0)
        ) else $error("credit on empty ovc %0d", k);

        a_no_overflow: assert property (
            @(posedge clk) disable iff (reset)
            (ovc_wr[k] && !credit_in[k]) |-> (depth[k] != vc_state_pkg::depth_t'(B))
        ) else $error("write into full ovc %0d", k);
    end

endmodule

// File: hw/router_vc_ctrl.sv
`timescale 1ns/1ps

module router_vc_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    // from input buffers and routing
    input  noc_geom_pkg::pv_vec_t  ivc_request_all,
    input  noc_geom_pkg::pv_vec_t  flit_is_tail_all,
    input  noc_geom_pkg::pv_dest_t dest_port_all,
    input  noc_geom_pkg::pvv_vec_t candidate_ovc_all,

    // from vc and switch allocators
    input  noc_geom_pkg::pv_vec_t  ivc_ovc_grant_all,
    input  noc_geom_pkg::pvv_vec_t granted_ovc_num_all,
    input  noc_geom_pkg::pv_vec_t  ivc_sw_grant_all,
    input  noc_geom_pkg::pv_vec_t  ovc_allocated_all,
    input  noc_geom_pkg::pv_vec_t  ovc_released_all,

    // downstream side
    input  noc_geom_pkg::pv_vec_t  ovc_wr_all,
    input  noc_geom_pkg::pv_vec_t  credit_in_all,
    output noc_geom_pkg::pv_vec_t  credit_out_all,

    // to the allocators
    output noc_geom_pkg::pv_vec_t  ovc_is_assigned_all,
    output noc_geom_pkg::pvv_vec_t assigned_ovc_num_all,
    output noc_geom_pkg::pvv_vec_t masked_ovc_request_all,
    output noc_geom_pkg::pv_vec_t  assigned_ovc_not_full_all,
    output noc_geom_pkg::pv_vec_t  ovc_empty_all
);

    noc_geom_pkg::pv_vec_t ovc_available;   // not owned by a packet
    noc_geom_pkg::pv_vec_t ovc_nearly_full;

    vc_grant_if grant_bus ();

    assign grant_bus.ivc_ovc_grant   = ivc_ovc_grant_all;
    assign grant_bus.granted_ovc_num = granted_ovc_num_all;
    assign grant_bus.ivc_sw_grant    = ivc_sw_grant_all;
    assign grant_bus.flit_is_tail    = flit_is_tail_all;

    // input side state
    ivc_assign_tracker ivc_trk (
        .clk              (clk),
        .reset            (reset),
        .grant            (grant_bus.tracker),
        .ovc_is_assigned  (ovc_is_assigned_all),
        .assigned_ovc_num (assigned_ovc_num_all),
        .credit_out       (credit_out_all)
    );

    // output side state
    ovc_credit_tracker ovc_trk (
        .clk             (clk),
        .reset           (reset),
        .ovc_wr          (ovc_wr_all),
        .credit_in       (credit_in_all),
        .ovc_allocated   (ovc_allocated_all),
        .ovc_released    (ovc_released_all),
        .ovc_available   (ovc_available),
        .ovc_nearly_full (ovc_nearly_full),
        .ovc_empty       (ovc_empty_all)
    );

    vc_request_masker req_mask (
        .ivc_request           (ivc_request_all),
        .dest_port             (dest_port_all),
        .candidate_ovc         (candidate_ovc_all),
        .ovc_is_assigned       (ovc_is_assigned_all),
        .assigned_ovc_num      (assigned_ovc_num_all),
        .ovc_available         (ovc_available),
        .ovc_nearly_full       (ovc_nearly_full),
        .masked_ovc_request    (masked_ovc_request_all),
        .assigned_ovc_not_full (assigned_ovc_not_full_all)
    );

endmodule

// File: hw/vc_grant_if.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

interface vc_grant_if;

    localparam int PV  = `NOC_PORTS * `NOC_VCS;
    localparam int PVV = PV * `NOC_VCS;

    logic [PV-1:0]  ivc_ovc_grant;   // vc allocator won, per input VC
    logic [PVV-1:0] granted_ovc_num; // one-hot ovc, valid with ivc_ovc_grant
    logic [PV-1:0]  ivc_sw_grant;    // switch allocator won
    logic [PV-1:0]  flit_is_tail;    // head flit of the VC is a tail

    // allocator side
    modport source (
        output ivc_ovc_grant,
        output granted_ovc_num,
        output ivc_sw_grant,
        output flit_is_tail
    );

    modport tracker (
        input ivc_ovc_grant,
        input granted_ovc_num,
        input ivc_sw_grant,
        input flit_is_tail
    );

endinterface

// File: hw/vc_request_masker.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module vc_request_masker (
    input  noc_geom_pkg::pv_vec_t  ivc_request,
    input  noc_geom_pkg::pv_dest_t dest_port,
    input  noc_geom_pkg::pvv_vec_t candidate_ovc,
    input  noc_geom_pkg::pv_vec_t  ovc_is_assigned,
    input  noc_geom_pkg::pvv_vec_t assigned_ovc_num,
    input  noc_geom_pkg::pv_vec_t  ovc_available,
    input  noc_geom_pkg::pv_vec_t  ovc_nearly_full,
    output noc_geom_pkg::pvv_vec_t masked_ovc_request,
    output noc_geom_pkg::pv_vec_t  assigned_ovc_not_full
);

    localparam int P  = `NOC_PORTS;
    localparam int V  = `NOC_VCS;
    localparam int PV = P * V;

    noc_geom_pkg::pv_vec_t vc_req; // still looking for an output VC

    assign vc_req = ivc_request & ~ovc_is_assigned;

    for (genvar i = 0; i < PV; i++) begin : g_ivc
        localparam int OWN = i / V; // input port of this VC

        noc_geom_pkg::dest_port_t dest;
        noc_geom_pkg::vc_vec_t    avail_sel;  // availability at dest port
        noc_geom_pkg::vc_vec_t    nfull_sel;  // nearly full at dest port
        vc_state_pkg::ovc_num_t   cand;
        vc_state_pkg::ovc_num_t   asg_num;

        assign dest    = dest_port[i*(P-1) +: P-1];
        assign cand    = candidate_ovc[i*V +: V];
        assign asg_num = assigned_ovc_num[i*V +: V];

        // one-hot mux over the other ports, ascending, own port skipped
        always_comb begin
            int port;
            avail_sel = '0;
            nfull_sel = '0;
            for (int j = 0; j < P - 1; j++) begin
                port = (j < OWN) ? j : j + 1;
                if (dest[j]) begin
                    avail_sel |= ovc_available[port*V +: V];
                    nfull_sel |= ovc_nearly_full[port*V +: V];
                end
            end
        end

        assign masked_ovc_request[i*V +: V] = vc_req[i] ? (cand & avail_sel) : '0;

        // assigned number is one-hot, so this picks its own nearly-full bit
        assign assigned_ovc_not_full[i] = ovc_is_assigned[i] & (|(asg_num & ~nfull_sel));

        // routing must name exactly one port while the VC competes
        always_comb begin
            a_dest_onehot: assert final (!vc_req[i] || $onehot(dest))
                else $error("ivc %0d requests with bad dest_port %b", i, dest);
        end
    end

endmodule

// File: hw/vc_state_pkg.sv
`include "noc_cfg.svh"

package vc_state_pkg;

    localparam int V = `NOC_VCS;
    localparam int B = `NOC_BUF_DEPTH;

    // must hold the value B itself
    localparam int DEPTH_W = $clog2(B + 1);

    typedef logic [V-1:0] ovc_num_t; // one-hot output VC number

    // flits in flight towards one downstream VC
    typedef logic [DEPTH_W-1:0] depth_t;

endpackage

// File: router_vc_ctrl.f
+incdir+hw
hw/noc_geom_pkg.sv
hw/vc_state_pkg.sv
hw/vc_grant_if.sv
hw/ivc_assign_tracker.sv
hw/ovc_credit_tracker.sv
hw/vc_request_masker.sv
hw/router_vc_ctrl.sv
sim/router_vc_ctrl_tb.sv

// File: sim/router_vc_ctrl_tb.sv
`timescale 1ns/1ps
`include "noc_cfg.svh"

module router_vc_ctrl_tb;

    localparam int P  = `NOC_PORTS;
    localparam int V  = `NOC_VCS;
    localparam int B  = `NOC_BUF_DEPTH;
    localparam int PV = P * V;

    localparam int RESET_CYCLES   = 10;
    localparam int TEST_CYCLES    = 1000;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic clk;
    logic reset;

    noc_geom_pkg::pv_vec_t  ivc_request_all, flit_is_tail_all, ivc_ovc_grant_all;
    noc_geom_pkg::pv_vec_t  ivc_sw_grant_all, ovc_wr_all, credit_in_all;
    noc_geom_pkg::pv_vec_t  ovc_allocated_all, ovc_released_all;
    noc_geom_pkg::pv_dest_t dest_port_all;
    noc_geom_pkg::pvv_vec_t candidate_ovc_all, granted_ovc_num_all;

    noc_geom_pkg::pv_vec_t  credit_out_all, ovc_is_assigned_all;
    noc_geom_pkg::pv_vec_t  assigned_ovc_not_full_all, ovc_empty_all;
    noc_geom_pkg::pvv_vec_t assigned_ovc_num_all, masked_ovc_request_all;

    // reference state
    noc_geom_pkg::pv_vec_t  m_assigned;
    noc_geom_pkg::pvv_vec_t m_num;
    noc_geom_pkg::pv_vec_t  m_owned;
    noc_geom_pkg::pv_vec_t  m_prev_sw;   // last cycle's switch grants
    int                     m_depth [PV];

    noc_geom_pkg::pvv_vec_t exp_masked;
    noc_geom_pkg::pv_vec_t  exp_not_full, exp_empty;

    logic [31:0] lcg_state = 32'ha405_e6f5;
    int          errors = 0;
    int          checks_done = 0;
    int          cycle_count = 0;

    router_vc_ctrl dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = next_rand();
        return (r[31:16] % 100) < pct;
    endfunction

    // expected combinational outputs from the model state and current inputs
    function automatic void expected_outputs(
        output noc_geom_pkg::pvv_vec_t masked,
        output noc_geom_pkg::pv_vec_t  not_full,
        output noc_geom_pkg::pv_vec_t  empty
    );
        int own;
        int port;
        noc_geom_pkg::vc_vec_t avail;
        masked   = '0;
        not_full = '0;
        empty    = '0;
        for (int k = 0; k < PV; k++) begin
            empty[k] = (m_depth[k] == 0);
        end
        for (int i = 0; i < PV; i++) begin
            own  = i / V;
            port = -1;
            for (int j = 0; j < P - 1; j++) begin
                if (dest_port_all[i*(P-1) + j]) begin
                    port = (j < own) ? j : j + 1; // skip own port
                end
            end
            if (port < 0) continue;
            avail = ~m_owned[port*V +: V];
            if (ivc_request_all[i] && !m_assigned[i]) begin
                masked[i*V +: V] = candidate_ovc_all[i*V +: V] & avail;
            end
            for (int v = 0; v < V; v++) begin
                if (m_assigned[i] && m_num[i*V + v]) begin
                    not_full[i] = (m_depth[port*V + v] < B - 1);
                end
            end
        end
    endfunction

    task automatic reset_model();
        m_assigned = '0;
        m_num      = '0;
        m_owned    = '0;
        m_prev_sw  = '0;
        for (int k = 0; k < PV; k++) begin
            m_depth[k] = 0;
        end
    endtask

    // state change at a rising edge
    task automatic advance_model();
        for (int k = 0; k < PV; k++) begin
            if (ivc_sw_grant_all[k] && flit_is_tail_all[k]) begin
                m_assigned[k] = 1'b0;
            end else if (ivc_ovc_grant_all[k]) begin
                m_assigned[k] = 1'b1;
            end
            if (ivc_ovc_grant_all[k]) begin
                m_num[k*V +: V] = granted_ovc_num_all[k*V +: V];
            end
            if (ovc_wr_all[k] && !credit_in_all[k]) begin
                m_depth[k]++;
            end else if (credit_in_all[k] && !ovc_wr_all[k]) begin
                m_depth[k]--;
            end
        end
        m_owned   = (m_owned & ~ovc_released_all) | ovc_allocated_all;
        m_prev_sw = ivc_sw_grant_all;
    endtask

    task automatic check_vec(
        input string                  name,
        input noc_geom_pkg::pvv_vec_t got,
        input noc_geom_pkg::pvv_vec_t want
    );
        checks_done++;
        assert (got === want) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
            $display("** FAIL **");
            $fatal(1, "%s differs from the reference", name);
        end
    endtask

    task automatic check_after_reset();
        noc_geom_pkg::pv_vec_t all_ones;
        all_ones = '1;
        check_vec("credit_out_all", credit_out_all, '0);
        check_vec("ovc_is_assigned_all", ovc_is_assigned_all, '0);
        check_vec("assigned_ovc_num_all", assigned_ovc_num_all, '0);
        check_vec("masked_ovc_request_all", masked_ovc_request_all, '0);
        check_vec("assigned_ovc_not_full_all", assigned_ovc_not_full_all, '0);
        check_vec("ovc_empty_all", ovc_empty_all, all_ones);
    endtask

    task automatic clear_inputs();
        ivc_request_all     = '0;
        flit_is_tail_all    = '0;
        ivc_ovc_grant_all   = '0;
        ivc_sw_grant_all    = '0;
        ovc_wr_all          = '0;
        credit_in_all       = '0;
        ovc_allocated_all   = '0;
        ovc_released_all    = '0;
        dest_port_all       = '0;
        candidate_ovc_all   = '0;
        granted_ovc_num_all = '0;
    endtask

    // random strobes kept inside the rules the RTL asserts
    task automatic drive_random_inputs();
        logic [31:0] r;
        logic        wr;
        logic        cr;
        for (int k = 0; k < PV; k++) begin
            r = next_rand();
            ivc_request_all[k]   = chance(60);
            flit_is_tail_all[k]  = chance(30);
            ivc_sw_grant_all[k]  = chance(30);
            ivc_ovc_grant_all[k] = chance(15);
            if (ivc_sw_grant_all[k] && flit_is_tail_all[k]) begin
                ivc_ovc_grant_all[k] = 1'b0; // no release and assign together
            end
            granted_ovc_num_all[k*V +: V] = noc_geom_pkg::vc_vec_t'(1) << (r[20:16] % V);
            candidate_ovc_all[k*V +: V]   = r[24 +: V];
            dest_port_all[k*(P-1) +: P-1] = noc_geom_pkg::dest_port_t'(1) << (r[12:8] % (P-1));
            wr = chance(40);
            cr = chance(40);
            if (wr && !cr && m_depth[k] == B) wr = 1'b0;
            if (cr && !wr && m_depth[k] == 0) cr = 1'b0;
            ovc_wr_all[k]        = wr;
            credit_in_all[k]     = cr;
            ovc_allocated_all[k] = chance(10);
            ovc_released_all[k]  = chance(10);
        end
    endtask

    // comparing process, model follows the DUT edge by edge
    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            expected_outputs(exp_masked, exp_not_full, exp_empty);
            check_vec("credit_out_all", credit_out_all, m_prev_sw);
            check_vec("ovc_is_assigned_all", ovc_is_assigned_all, m_assigned);
            check_vec("assigned_ovc_num_all", assigned_ovc_num_all, m_num);
            check_vec("ovc_empty_all", ovc_empty_all, exp_empty);
            check_vec("masked_ovc_request_all", masked_ovc_request_all, exp_masked);
            check_vec("assigned_ovc_not_full_all", assigned_ovc_not_full_all, exp_not_full);
            advance_model();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_after_reset();
        reset = 1'b0;
        repeat (TEST_CYCLES) begin
            @(negedge clk);
            drive_random_inputs();
        end
        @(negedge clk); // last stimulus checked at the edge before
        if (errors == 0 && checks_done > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule
